//--- files.f
hw/rv32i_fetch_pkg.sv
hw/fetch_bus_if.sv
hw/pc_gen.sv
hw/resp_filter.sv
hw/fetch_queue.sv
hw/fetch_unit.sv
sim/tb_fetch_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the fetch unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_fetch_unit \
    -f files.f \
    -o sim_fetch_unit

./obj_dir/sim_fetch_unit | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

grep -q "Test passed" sim.log
echo "simulation finished cleanly"

//--- sim/tb_fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_unit
    import rv32i_fetch_pkg::*;
();

    localparam int    DEPTH     = 16;
    localparam word_t DATA_KEY  = 32'hA5A5_0000;  // memory data is addr ^ key
    localparam int    LIM_SEQ   = 200;            // cycle limits per wait
    localparam int    LIM_FILL  = 150;
    localparam int    LIM_DRAIN = 150;
    localparam int    LIM_REDIR = 100;
    localparam int    LIM_STALL = 400;
    localparam int    TOTAL_CYCLES = 20 + LIM_SEQ + LIM_FILL + LIM_DRAIN + 5 * LIM_REDIR
                                     + LIM_STALL;

    logic         clk = 1'b0;
    logic         rst;
    logic         flush;
    logic         jalr_done;
    logic         jump_en;
    word_t        missed_pc;
    word_t        jalr_pc;
    word_t        pc_jump;
    logic         imem_stall;
    logic         imem_resp  = 1'b0;  // memory model outputs
    word_t        imem_raddr = '0;
    word_t        imem_rdata = '0;
    logic         request_new_instr;
    logic         imem_read;
    word_t        imem_addr;
    logic [63:0]  instruction;
    logic         instr_valid;

    integer       seed = 49;
    int           val_errs = 0;       // wrong values
    int           other_errs = 0;     // missing progress
    int           pop_cnt = 0;
    int           accepted_cnt = 0;   // reads taken by memory
    int           cyc = 0;
    int           last_due = 0;       // keeps answers in order
    int           lat;
    int           due;
    word_t        exp_pc;             // next pc decode should see
    fetch_entry_t exp_entry;
    word_t        pend_addr[$];       // reads waiting for an answer
    int           pend_due[$];

    fetch_unit #(
        .FQ_DEPTH (DEPTH),
        .RESET_PC (RESET_PC_DEF)
    ) dut0 (
        .clk               (clk),
        .rst               (rst),
        .flush             (flush),
        .missed_pc         (missed_pc),
        .jalr_done         (jalr_done),
        .jalr_pc           (jalr_pc),
        .jump_en           (jump_en),
        .pc_jump           (pc_jump),
        .imem_stall        (imem_stall),
        .imem_resp         (imem_resp),
        .imem_raddr        (imem_raddr),
        .imem_rdata        (imem_rdata),
        .imem_read         (imem_read),
        .imem_addr         (imem_addr),
        .request_new_instr (request_new_instr),
        .instruction       (instruction),
        .instr_valid       (instr_valid)
    );

    always #10 clk = ~clk;  // 20 ns period

    // in-order memory model with 1 to 3 cycles latency
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (rst) begin
            pend_addr.delete();
            pend_due.delete();
            last_due = 0;
        end else if (imem_read && !imem_stall) begin
            lat = 1 + (($random(seed) & 32'h7fff_ffff) % 3);
            due = cyc + lat;
            if (due <= last_due) begin
                due = last_due + 1;  // one answer per cycle
            end
            last_due = due;
            pend_addr.push_back(imem_addr);
            pend_due.push_back(due);
            accepted_cnt = accepted_cnt + 1;
        end
        #1;
        if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
            imem_resp  = 1'b1;
            imem_raddr = pend_addr.pop_front();
            imem_rdata = imem_raddr ^ DATA_KEY;
            pend_due.pop_front();
        end else begin
            imem_resp  = 1'b0;
            imem_raddr = '0;
            imem_rdata = '0;
        end
    end

    // scoreboard on the decode side
    always @(posedge clk) begin
        if (rst) begin
            exp_pc = RESET_PC_DEF;
        end else begin
            if (request_new_instr && instr_valid) begin
                exp_entry.pc    = exp_pc;
                exp_entry.instr = exp_pc ^ DATA_KEY;
                check_entry("instruction", fetch_entry_t'(instruction), exp_entry);
                exp_pc  = exp_pc + 32'd4;
                pop_cnt = pop_cnt + 1;
            end
            // flush first, then jalr, then jump
            if (flush) begin
                exp_pc = missed_pc;
            end else if (jalr_done) begin
                exp_pc = jalr_pc;
            end else if (jump_en) begin
                exp_pc = pc_jump;
            end
        end
    end

    task automatic check_entry(input string name, input fetch_entry_t got,
                               input fetch_entry_t exp);
        if (got !== exp) begin
            val_errs = val_errs + 1;
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            val_errs = val_errs + 1;
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;  // drive just after the edge
    endtask

    // wait for n more pops and give up after limit cycles
    task automatic wait_pops(input int n, input int limit, input string what);
        int target;
        int waited;
        target = pop_cnt + n;
        waited = 0;
        while (pop_cnt < target && waited < limit) begin
            tick();
            waited = waited + 1;
        end
        if (pop_cnt < target) begin
            other_errs = other_errs + 1;
            $display("%s: only %0d of %0d entries reached decode in %0d cycles",
                     what, n - (target - pop_cnt), n, limit);
        end
    endtask

    task automatic send_redirect(input logic f, input word_t m, input logic jr,
                                 input word_t jp, input logic j, input word_t pj);
        flush     = f;
        missed_pc = m;
        jalr_done = jr;
        jalr_pc   = jp;
        jump_en   = j;
        pc_jump   = pj;
        tick();             // single cycle strobe
        flush     = 1'b0;
        jalr_done = 1'b0;
        jump_en   = 1'b0;
    endtask

    task automatic reset_state();
        repeat (9) tick();
        check_word("imem_read", word_t'(imem_read), 32'd0);  // quiet in reset
        tick();
        rst = 1'b0;
        check_word("imem_addr", imem_addr, RESET_PC_DEF);
        check_word("instr_valid", word_t'(instr_valid), 32'd0);
    endtask

    task automatic sequential_stream();
        request_new_instr = 1'b1;
        wait_pops(40, LIM_SEQ, "sequential stream");
    endtask

    task automatic fill_and_drain();
        int low_run;
        int n;
        request_new_instr = 1'b0;  // decode stops
        low_run = 0;
        n = 0;
        while (low_run < 12 && n < LIM_FILL) begin
            tick();
            low_run = imem_read ? 0 : low_run + 1;
            n = n + 1;
        end
        if (low_run < 12) begin
            other_errs = other_errs + 1;
            $display("fetch kept reading memory with decode stopped");
        end
        // nothing dropped so far, so taken minus popped is what sits in the queue
        check_word("buffered entries", word_t'(accepted_cnt - pop_cnt), word_t'(DEPTH));
        check_word("instr_valid", word_t'(instr_valid), 32'd1);
        request_new_instr = 1'b1;
        wait_pops(40, LIM_DRAIN, "drain after back-pressure");
    endtask

    task automatic jump_then_jalr();
        wait_pops(10, LIM_REDIR, "before jump");
        send_redirect(1'b0, '0, 1'b0, '0, 1'b1, 32'h0000_2000);
        wait_pops(20, LIM_REDIR, "after jump");
        send_redirect(1'b0, '0, 1'b1, 32'h0000_3100, 1'b0, '0);
        wait_pops(20, LIM_REDIR, "after jalr");
    endtask

    task automatic redirect_priority();
        send_redirect(1'b1, 32'h0000_4000, 1'b1, 32'h0000_5000, 1'b1, 32'h0000_6000);
        wait_pops(20, LIM_REDIR, "after flush with jalr and jump");
        send_redirect(1'b0, '0, 1'b1, 32'h0000_7000, 1'b1, 32'h0000_8000);
        wait_pops(20, LIM_REDIR, "after jalr with jump");
    endtask

    task automatic stream_under_stalls();
        int target;
        int n;
        target = pop_cnt + 40;
        n = 0;
        while (pop_cnt < target && n < LIM_STALL) begin
            tick();
            imem_stall = ($random(seed) & 32'sd1) != 0;
            n = n + 1;
        end
        tick();
        imem_stall = 1'b0;
        if (pop_cnt < target) begin
            other_errs = other_errs + 1;
            $display("stream stopped under random memory stalls");
        end
    endtask

    initial begin
        rst               = 1'b1;
        flush             = 1'b0;
        missed_pc         = '0;
        jalr_done         = 1'b0;
        jalr_pc           = '0;
        jump_en           = 1'b0;
        pc_jump           = '0;
        imem_stall        = 1'b0;
        request_new_instr = 1'b0;
        reset_state();
        sequential_stream();
        fill_and_drain();
        jump_then_jalr();
        redirect_priority();
        stream_under_stalls();
        tick();
        $display("done: %0d value errors, %0d other errors", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog at twice the summed test limits
    initial begin
        #(TOTAL_CYCLES * 40);
        $display("timeout: the tests did not finish in %0d cycles", TOTAL_CYCLES * 2);
        $display("Test failed");
        $finish;
    end

endmodule : tb_fetch_unit

`default_nettype wire

//--- hw/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
    import rv32i_fetch_pkg::*;
#(
    parameter int    FQ_DEPTH = FQ_DEPTH_DEF,
    parameter word_t RESET_PC = RESET_PC_DEF
) (
    input  wire logic        clk,
    input  wire logic        rst,
    // redirects
    input  wire logic        flush,
    input  wire logic [31:0] missed_pc,
    input  wire logic        jalr_done,
    input  wire logic [31:0] jalr_pc,
    input  wire logic        jump_en,
    input  wire logic [31:0] pc_jump,
    // instruction memory
    input  wire logic        imem_stall,
    input  wire logic        imem_resp,
    input  wire logic [31:0] imem_raddr,
    input  wire logic [31:0] imem_rdata,
    output logic             imem_read,
    output logic [31:0]      imem_addr,
    // decode side
    input  wire logic        request_new_instr,
    output logic [63:0]      instruction,   // {pc, instr}
    output logic             instr_valid
);

    fetch_bus_if  bus0 ();     // gen / filt / queue handshake
    word_t        pc;          // current fetch address
    fetch_entry_t head_entry;  // queue head, flattened below

    assign imem_addr   = pc;
    assign instruction = head_entry;

    pc_gen #(
        .FQ_DEPTH (FQ_DEPTH),
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .missed_pc  (missed_pc),
        .jalr_done  (jalr_done),
        .jalr_pc    (jalr_pc),
        .jump_en    (jump_en),
        .pc_jump    (pc_jump),
        .imem_stall (imem_stall),
        .imem_read  (imem_read),
        .pc         (pc),
        .bus        (bus0.gen)
    );

    resp_filter #(
        .RESET_PC (RESET_PC)   // must agree with pc_gen start
    ) u_resp_filter (
        .clk        (clk),
        .rst        (rst),
        .imem_resp  (imem_resp),
        .imem_raddr (imem_raddr),
        .imem_rdata (imem_rdata),
        .bus        (bus0.filt)
    );

    fetch_queue #(
        .FQ_DEPTH (FQ_DEPTH)
    ) u_fetch_queue (
        .clk               (clk),
        .rst               (rst),
        .request_new_instr (request_new_instr),
        .instr_valid       (instr_valid),
        .instruction       (head_entry),
        .bus               (bus0.queue)
    );

endmodule : fetch_unit

`default_nettype wire

//--- hw/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_queue
    import rv32i_fetch_pkg::*;
#(
    parameter int FQ_DEPTH = FQ_DEPTH_DEF
) (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    request_new_instr, // decode wants the head
    output logic         instr_valid,
    output fetch_entry_t instruction,
    fetch_bus_if.queue   bus
);

    localparam int PTR_W = $clog2(FQ_DEPTH); // depth is a power of two, ptrs wrap

    fetch_entry_t     mem [FQ_DEPTH];     // slot storage
    fetch_entry_t     head_q;             // registered copy of the oldest entry
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_nxt;             // read pointer after this edge
    fetch_cnt_t       count_q;

    assign instr_valid = (count_q != '0);
    assign instruction = head_q;
    assign bus.count   = count_q;
    assign bus.pop     = request_new_instr && instr_valid;

    assign rd_nxt = rd_ptr_q + PTR_W'(bus.pop);

    // storage write
    always_ff @(posedge clk) begin
        if (bus.push) begin
            mem[wr_ptr_q] <= bus.push_entry;
        end
    end

    // head register
    // bypass when the push lands exactly where the head will sit
    always_ff @(posedge clk) begin
        if (bus.push && (wr_ptr_q == rd_nxt)) begin
            head_q <= bus.push_entry;   // queue empty after this edge's pop
        end else begin
            head_q <= mem[rd_nxt];
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst || bus.redirect) begin
            rd_ptr_q <= '0;             // drop the whole old path
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            rd_ptr_q <= rd_nxt;
            if (bus.push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            case ({bus.push, bus.pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // pc_gen reserves a slot per read, so a full queue sees no push
    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst)
        bus.push |-> (int'(count_q) < FQ_DEPTH)
    );

    // occupancy stays within the array
    a_count_in_range: assert property (
        @(posedge clk) disable iff (rst)
        int'(count_q) <= FQ_DEPTH
    );

endmodule : fetch_queue

`default_nettype wire

//--- hw/resp_filter.sv
`timescale 1ns/1ps
`default_nettype none

module resp_filter
    import rv32i_fetch_pkg::*;
#(
    parameter word_t RESET_PC = RESET_PC_DEF
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  imem_resp,
    input  wire word_t imem_raddr,
    input  wire word_t imem_rdata,
    fetch_bus_if.filt  bus
);

    // extra bit since old reads from several redirects can pile up
    localparam int SKIP_W = $bits(fetch_cnt_t) + 1;

    word_t             expect_q;   // address the next useful response must carry
    logic [SKIP_W-1:0] inflight_q; // every read still inside memory, any path
    logic [SKIP_W-1:0] stale_q;    // responses still owed to an abandoned path
    logic              live;       // response belongs to the current path

    // memory answers in order, so the first stale_q responses are old path
    assign live = imem_resp && !bus.redirect && (stale_q == '0);

    assign bus.ret        = live;                             // credit back to pc_gen
    assign bus.push       = live && (imem_raddr == expect_q); // repeats drop out here
    assign bus.push_entry = {imem_raddr, imem_rdata};

    // expected address
    always_ff @(posedge clk) begin
        if (rst) begin
            expect_q <= RESET_PC;
        end else if (bus.redirect) begin
            expect_q <= bus.redirect_pc;
        end else if (bus.push) begin
            expect_q <= expect_q + PC_STEP;
        end
    end

    // total reads in memory
    always_ff @(posedge clk) begin
        if (rst) begin
            inflight_q <= '0;
        end else begin
            inflight_q <= inflight_q + SKIP_W'(bus.issue) - SKIP_W'(imem_resp);
        end
    end

    // stale responses to swallow
    always_ff @(posedge clk) begin
        if (rst) begin
            stale_q <= '0;
        end else if (bus.redirect) begin
            stale_q <= inflight_q - SKIP_W'(imem_resp); // everything in flight is old now
        end else if (imem_resp && (stale_q != '0)) begin
            stale_q <= stale_q - 1'b1;
        end
    end

    // memory never answers a read nobody issued
    a_resp_was_issued: assert property (
        @(posedge clk) disable iff (rst)
        imem_resp |-> (inflight_q != '0)
    );

endmodule : resp_filter

`default_nettype wire

//--- hw/pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pc_gen
    import rv32i_fetch_pkg::*;
#(
    parameter int    FQ_DEPTH = FQ_DEPTH_DEF,
    parameter word_t RESET_PC = RESET_PC_DEF
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  flush,      // mispredict / exception recovery
    input  wire word_t missed_pc,
    input  wire logic  jalr_done,  // jalr resolved in the backend
    input  wire word_t jalr_pc,
    input  wire logic  jump_en,    // jal from decode
    input  wire word_t pc_jump,
    input  wire logic  imem_stall,
    output logic       imem_read,
    output word_t      pc,
    fetch_bus_if.gen   bus
);

    logic                        started_q; // low until first edge out of reset
    fetch_cnt_t                  out_q;     // reads in flight on the current path
    logic [$bits(fetch_cnt_t):0] budget;    // outstanding + queued, one extra bit
    logic                        room;      // space reserved for one more read

    // redirect source select
    // flush beats jalr, jalr beats jump
    always_comb begin
        bus.redirect = flush | jalr_done | jump_en;
        if (flush) begin
            bus.redirect_pc = missed_pc;
        end else if (jalr_done) begin
            bus.redirect_pc = jalr_pc;
        end else begin
            bus.redirect_pc = pc_jump;
        end
    end

    assign budget = out_q + bus.count;

    // a pop this edge frees one slot, so it may be spent right away
    assign room = int'(budget) < (FQ_DEPTH + int'(bus.pop));

    assign imem_read = started_q && !bus.redirect && room; // no reads while steering
    assign bus.issue = imem_read && !imem_stall;           // memory took it

    // pc register
    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= RESET_PC;
            started_q <= 1'b0;
        end else begin
            started_q <= 1'b1;
            if (bus.redirect) begin
                pc <= bus.redirect_pc;     // new path
            end else if (bus.issue) begin
                pc <= pc + PC_STEP;        // next sequential word
            end
            // stall or full budget -> hold
        end
    end

    // outstanding credits
    // old-path reads are forgotten here, the filter swallows their responses
    always_ff @(posedge clk) begin
        if (rst || bus.redirect) begin
            out_q <= '0;
        end else begin
            case ({bus.issue, bus.ret})
                2'b10:   out_q <= out_q + 1'b1;
                2'b01:   out_q <= out_q - 1'b1;
                default: out_q <= out_q;   // none, or one in and one out
            endcase
        end
    end

    // a credit only comes back for a read this module handed out
    a_out_no_underflow: assert property (
        @(posedge clk) disable iff (rst)
        bus.ret |-> (out_q != '0)
    );

    // reserved reads never exceed what the queue can take
    a_out_in_range: assert property (
        @(posedge clk) disable iff (rst)
        int'(out_q) <= FQ_DEPTH
    );

endmodule : pc_gen

`default_nettype wire

//--- hw/fetch_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fetch_bus_if
    import rv32i_fetch_pkg::*;
();

    logic         redirect;     // one-cycle strobe, any redirect source
    word_t        redirect_pc;  // winning target
    logic         issue;        // read accepted by memory this cycle
    logic         ret;          // current-path response, returns one credit
    logic         push;         // filtered response goes into the queue
    fetch_entry_t push_entry;   // {raddr, rdata}
    fetch_cnt_t   count;        // entries held in the queue
    logic         pop;          // entry leaves the queue this cycle

    // pc generator
    modport gen (
        output redirect, redirect_pc, issue,
        input  ret, count, pop
    );

    // response filter
    modport filt (
        input  redirect, redirect_pc, issue,
        output ret, push, push_entry
    );

    // fetch queue
    modport queue (
        input  redirect, push, push_entry,
        output count, pop
    );

endinterface : fetch_bus_if

`default_nettype wire

//--- hw/rv32i_fetch_pkg.sv
`default_nettype none

package rv32i_fetch_pkg;

    // basic rv32i word, used for both addresses and instructions
    typedef logic [31:0] word_t;

    // one queue slot, pc on top, raw instruction below
    typedef struct packed {
        word_t pc;     // fetch address of this instruction
        word_t instr;  // instruction bits as returned by memory
    } fetch_entry_t;

    // default queue depth, power of two
    localparam int FQ_DEPTH_DEF = 16;

    // where fetch starts out of reset
    localparam word_t RESET_PC_DEF = 32'h0000_1000;

    // byte step between sequential fetches
    localparam word_t PC_STEP = 32'd4;

    // counts must reach FQ_DEPTH_DEF itself, not just depth-1
    localparam int FETCH_CNT_W = $clog2(FQ_DEPTH_DEF + 1);

    // occupancy and outstanding-request counts
    typedef logic [FETCH_CNT_W-1:0] fetch_cnt_t;

    // 0x10 -> 5 bits, enough for 0..16
    // a deeper queue needs FQ_DEPTH_DEF raised with it

endpackage : rv32i_fetch_pkg

`default_nettype wire
